/* design/debug_defs.svh */
`ifndef DEBUG_DEFS_SVH
`define DEBUG_DEFS_SVH

// Word width of the core datapath and of every debug transfer.
`define DEBUG_DATA_WIDTH 16
`define DEBUG_CREDITS 2      // Request credits, which is also the executor queue depth.
`define DEBUG_MEM_DEPTH 256  // Words in the memory the debugger can reach.

// Host register map on the 8-bit bus. Address 7 is unused and reads as zero.
`define DEBUG_REG_MODE   3'd0
`define DEBUG_REG_OP     3'd1
`define DEBUG_REG_DL     3'd2 // Data word, low byte.
`define DEBUG_REG_DH     3'd3 // Data word, high byte.
`define DEBUG_REG_AL     3'd4 // Address, low byte. Bit 0 is always zero.
`define DEBUG_REG_AH     3'd5
`define DEBUG_REG_STATUS 3'd6

`endif

/* design/debugPkg.sv */
package debugPkg;

	// Selects one host register on the 3-bit bus address.
	typedef logic [2:0] hostRegAddr;

	// One host write after it has crossed into the CLK domain.
	typedef struct packed {
		logic       valid; // High for exactly one cycle per host write.
		hostRegAddr addr;  // Register that was written.
		logic [7:0] data;  // Byte the host put on the bus.
	} hostWrite;

	// Mode register as the host writes it.
	// Stop sits in bit 0 and clearFlags in bit 1.
	typedef struct packed {
		logic clearFlags; // Writing a one clears the sticky dropped flag.
		logic stop;       // Holds the core so that queued requests may run.
	} modeReg;

	// Op register as the host writes it.
	// Bit 0 enables address auto-increment, bits 3 to 1 carry the opcode.
	typedef struct packed {
		logic [2:0] opcode;        // Encoded as coreReqPkg::debugOp.
		logic       autoIncrement; // Step the address by one word per issued request.
	} opReg;

endpackage

/* design/coreReqPkg.sv */
`include "debug_defs.svh"

package coreReqPkg;

	// Operations the core side carries out for the debugger.
	typedef enum logic [2:0] {
		opNop      = 3'd0,
		opReadMem  = 3'd1,
		opWriteMem = 3'd2,
		opReadReg  = 3'd3,
		opWriteReg = 3'd4,
		opReadPc   = 3'd5,
		opWritePc  = 3'd6
	} debugOp;

	// One request from the port. The register index is addr[4:1].
	typedef struct packed {
		logic                         valid;
		debugOp                       op;
		logic [`DEBUG_DATA_WIDTH-1:0] addr; // Byte address with bit 0 at zero.
		logic [`DEBUG_DATA_WIDTH-1:0] data; // Write data, ignored by reads.
	} debugRequest;

	// Completion of one request. Each valid pulse gives one credit back.
	typedef struct packed {
		logic                         valid;
		logic                         hasData; // Set for the three read ops.
		logic [`DEBUG_DATA_WIDTH-1:0] data;
	} debugResponse;

	typedef enum logic [1:0] {stIdle, stMemRead, stRespond} execState;

endpackage

/* design/debugSync.sv */
`timescale 1ns/1ns

module debugSync (
	input  logic                 CLK,
	input  logic                 reset,
	input  debugPkg::hostRegAddr hostAddr,
	input  logic [7:0]           hostDin,
	input  logic                 hostWrn,
	output debugPkg::hostWrite   write
);

	logic                 wrnMeta;    // First stage. It may go metastable.
	logic                 wrnSync;    // Second stage, safe to use in the CLK domain.
	logic                 wrnLast;    // Delayed copy for the edge detector.
	logic                 writeValid; // Registered write event.
	debugPkg::hostRegAddr addrHold;
	logic [7:0]           dataHold;

	// The host keeps address and data stable while the strobe is low.
	// Every edge in that window samples them, so the last sample is the written value.
	always_ff @(posedge CLK) begin
		if (!hostWrn) begin
			addrHold <= hostAddr;
			dataHold <= hostDin;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wrnMeta    <= 1'b1; // The strobe idles high.
			wrnSync    <= 1'b1;
			wrnLast    <= 1'b1;
			writeValid <= 1'b0;
		end else begin
			wrnMeta    <= hostWrn;
			wrnSync    <= wrnMeta;
			wrnLast    <= wrnSync;
			writeValid <= wrnSync & ~wrnLast; // A rising strobe ends the host write.
		end
	end

	// The hold registers are frozen once the strobe is high, so they are settled
	// long before the event pulse on the third edge after the rise.
	assign write = '{valid: writeValid, addr: addrHold, data: dataHold};

endmodule

/* design/debugPort.sv */
`timescale 1ns/1ns
`include "debug_defs.svh"

module debugPort (
	input  logic                       CLK,
	input  logic                       reset,
	input  debugPkg::hostWrite         write,
	input  debugPkg::hostRegAddr       hostAddr,
	input  logic                       hostRdn,
	output logic [7:0]                 hostDout,
	output logic                       stop,
	output coreReqPkg::debugRequest    request,
	input  coreReqPkg::debugResponse   response
);

	debugPkg::modeReg             mode;
	debugPkg::modeReg             newMode;    // Mode byte of the current host write.
	debugPkg::opReg               op;
	debugPkg::opReg               newOp;      // Op byte of the current host write.
	logic [`DEBUG_DATA_WIDTH-1:0] addr;       // Word address with bit 0 held at zero.
	logic [`DEBUG_DATA_WIDTH-1:0] wrData;     // Data word assembled from DL and DH.
	logic [`DEBUG_DATA_WIDTH-1:0] wrDataNext; // Data word including this cycle's DH byte.
	logic [`DEBUG_DATA_WIDTH-1:0] rdData;     // Last data returned by the core side.
	logic [1:0]                   credits;
	logic                         readValid;
	logic                         dropped;    // Sticky. A request found no credit.
	logic                         writeMode;
	logic                         writeOp;
	logic                         writeDh;
	logic                         wantIssue;  // The host event asks for a request.
	logic                         issue;      // A credit is free and the request goes out.
	logic                         issueAuto;

	assign newMode   = debugPkg::modeReg'(write.data[1:0]);
	assign newOp     = debugPkg::opReg'(write.data[3:0]);
	assign writeMode = write.valid && (write.addr == `DEBUG_REG_MODE);
	assign writeOp   = write.valid && (write.addr == `DEBUG_REG_OP);
	assign writeDh   = write.valid && (write.addr == `DEBUG_REG_DH);

	// A streamed write must carry the high byte that triggered it.
	assign wrDataNext = writeDh ? {write.data, wrData[7:0]} : wrData;

	// An op write issues its new opcode. A DH write repeats the current op when streaming.
	assign wantIssue = writeOp || (writeDh && op.autoIncrement);
	assign issue     = wantIssue && (credits != 2'd0);
	assign issueAuto = writeOp ? newOp.autoIncrement : op.autoIncrement;
	assign stop      = mode.stop;

	always_ff @(posedge CLK) begin
		if (reset) begin
			mode      <= '0;
			op        <= '0;
			addr      <= '0;
			wrData    <= '0;
			rdData    <= '0;
			credits   <= 2'(`DEBUG_CREDITS);
			readValid <= 1'b0;
			dropped   <= 1'b0;
			request   <= '0;
		end else begin
			if (write.valid) begin
				case (write.addr)
					`DEBUG_REG_MODE: mode <= newMode;
					`DEBUG_REG_OP:   op <= newOp;
					`DEBUG_REG_DL:   wrData[7:0] <= write.data;
					`DEBUG_REG_DH:   wrData[15:8] <= write.data;
					`DEBUG_REG_AL:   addr[7:0] <= {write.data[7:1], 1'b0}; // Word aligned.
					`DEBUG_REG_AH:   addr[15:8] <= write.data;
					default:         ; // Status and address 7 ignore writes.
				endcase
			end
			// The address moves on as the request leaves, so several can be in flight.
			if (issue && issueAuto)
				addr <= addr + 'd2;
			request.valid <= issue; // One-cycle pulse.
			if (issue) begin
				request.op   <= coreReqPkg::debugOp'(writeOp ? newOp.opcode : op.opcode);
				request.addr <= addr;
				request.data <= wrDataNext;
			end
			// One credit leaves with each request and one returns with each response.
			case ({issue, response.valid})
				2'b10:   credits <= credits - 2'd1;
				2'b01:   credits <= credits + 2'd1;
				default: ;
			endcase
			if (issue)
				readValid <= 1'b0; // Old read data is stale once a new request is out.
			if (response.valid && response.hasData) begin
				readValid <= 1'b1;
				rdData    <= response.data;
			end
			if (wantIssue && !issue)
				dropped <= 1'b1;
			else if (writeMode && newMode.clearFlags)
				dropped <= 1'b0;
		end
	end

	// Read-back follows the bus address while the read strobe is low.
	always_comb begin
		hostDout = 8'h00;
		if (!hostRdn) begin
			case (hostAddr)
				`DEBUG_REG_MODE:   hostDout = {6'b0, mode};
				`DEBUG_REG_OP:     hostDout = {4'b0, op};
				`DEBUG_REG_DL:     hostDout = rdData[7:0];
				`DEBUG_REG_DH:     hostDout = rdData[15:8];
				`DEBUG_REG_AL:     hostDout = addr[7:0];
				`DEBUG_REG_AH:     hostDout = addr[15:8];
				`DEBUG_REG_STATUS: hostDout = {4'b0, dropped, readValid, credits};
				default:           hostDout = 8'h00;
			endcase
		end
	end

endmodule

/* design/debugExecutor.sv */
`timescale 1ns/1ns
`include "debug_defs.svh"

module debugExecutor (
	input  logic                                  CLK,
	input  logic                                  reset,
	input  logic                                  stop,
	input  coreReqPkg::debugRequest               request,
	output coreReqPkg::debugResponse              response,
	output logic [$clog2(`DEBUG_MEM_DEPTH)-1:0]   memAddr,
	output logic [`DEBUG_DATA_WIDTH-1:0]          memWrData,
	output logic                                  memWe,
	input  logic [`DEBUG_DATA_WIDTH-1:0]          memRdData
);

	localparam int queueDepth   = `DEBUG_CREDITS; // The port never has more in flight.
	localparam int ptrWidth     = (queueDepth > 1) ? $clog2(queueDepth) : 1;
	localparam int memAddrWidth = $clog2(`DEBUG_MEM_DEPTH);

	coreReqPkg::debugRequest      queue [queueDepth];
	logic [ptrWidth-1:0]          wrPtr;
	logic [ptrWidth-1:0]          rdPtr;
	logic [$clog2(queueDepth+1)-1:0] count;
	logic                         pop;
	coreReqPkg::debugRequest      cur;     // Request being carried out.
	coreReqPkg::execState         state;
	logic [`DEBUG_DATA_WIDTH-1:0] regBank [16];
	logic [`DEBUG_DATA_WIDTH-1:0] pc;
	logic [3:0]                   regIndex;
	logic [`DEBUG_DATA_WIDTH-1:0] readData;
	logic                         readOp;

	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		return (ptr == ptrWidth'(queueDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Requests leave the queue one at a time and only while the core is held.
	assign pop      = stop && (count != '0) && (state == coreReqPkg::stIdle);
	assign regIndex = cur.addr[4:1];
	assign readOp   = cur.op inside {coreReqPkg::opReadMem, coreReqPkg::opReadReg,
		coreReqPkg::opReadPc};

	// The memory sees the current request's word index throughout the operation.
	assign memAddr   = cur.addr[memAddrWidth:1];
	assign memWrData = cur.data;
	assign memWe     = (state == coreReqPkg::stRespond) && (cur.op == coreReqPkg::opWriteMem);

	always_comb begin
		case (cur.op)
			coreReqPkg::opReadMem: readData = memRdData;
			coreReqPkg::opReadReg: readData = regBank[regIndex];
			coreReqPkg::opReadPc:  readData = pc;
			default:               readData = '0; // Writes and nop return no data.
		endcase
	end

	always_ff @(posedge CLK) begin
		if (request.valid)
			queue[wrPtr] <= request;
		if (pop)
			cur <= queue[rdPtr];
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			state    <= coreReqPkg::stIdle;
			response <= '0;
			pc       <= '0;
			for (int i = 0; i < 16; i++)
				regBank[i] <= '0;
		end else begin
			response.valid <= 1'b0;
			if (request.valid)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({request.valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
			case (state)
				coreReqPkg::stIdle:
					if (pop) // A memory read needs one more cycle for the registered read.
						state <= (queue[rdPtr].op == coreReqPkg::opReadMem) ?
							coreReqPkg::stMemRead : coreReqPkg::stRespond;
				coreReqPkg::stMemRead:
					state <= coreReqPkg::stRespond; // The memory reads cur.addr on this edge.
				coreReqPkg::stRespond: begin
					state    <= coreReqPkg::stIdle;
					response <= '{valid: 1'b1, hasData: readOp, data: readData};
					if (cur.op == coreReqPkg::opWriteReg)
						regBank[regIndex] <= cur.data;
					if (cur.op == coreReqPkg::opWritePc)
						pc <= cur.data;
				end
				default: state <= coreReqPkg::stIdle;
			endcase
		end
	end

endmodule

/* design/debugMemory.sv */
`timescale 1ns/1ns
`include "debug_defs.svh"

module debugMemory (
	input  logic                                CLK,
	input  logic [$clog2(`DEBUG_MEM_DEPTH)-1:0] addr,   // Word index.
	input  logic [`DEBUG_DATA_WIDTH-1:0]        wrData,
	input  logic                                we,
	output logic [`DEBUG_DATA_WIDTH-1:0]        rdData
);

	logic [`DEBUG_DATA_WIDTH-1:0] mem [`DEBUG_MEM_DEPTH];

	// Single port. A write and a read at the same edge return the old word.
	always_ff @(posedge CLK) begin
		if (we)
			mem[addr] <= wrData;
		rdData <= mem[addr]; // Registered read, so data follows the address by one cycle.
	end

endmodule

/* design/debugSubsystem.sv */
`timescale 1ns/1ns
`include "debug_defs.svh"

module debugSubsystem (
	input  logic                 CLK,
	input  logic                 reset,
	input  debugPkg::hostRegAddr hostAddr,
	input  logic [7:0]           hostDin,
	output logic [7:0]           hostDout,
	input  logic                 hostRdn,
	input  logic                 hostWrn
);

	debugPkg::hostWrite                      write;    // Host write in the CLK domain.
	logic                                    stop;
	coreReqPkg::debugRequest                 request;
	coreReqPkg::debugResponse                response;
	logic [$clog2(`DEBUG_MEM_DEPTH)-1:0]     memAddr;
	logic [`DEBUG_DATA_WIDTH-1:0]            memWrData;
	logic                                    memWe;
	logic [`DEBUG_DATA_WIDTH-1:0]            memRdData;

	debugSync sync (.CLK(CLK), .reset(reset), .hostAddr(hostAddr), .hostDin(hostDin),
		.hostWrn(hostWrn), .write(write));

	debugPort port (.CLK(CLK), .reset(reset), .write(write), .hostAddr(hostAddr),
		.hostRdn(hostRdn), .hostDout(hostDout), .stop(stop), .request(request),
		.response(response));

	debugExecutor executor (.CLK(CLK), .reset(reset), .stop(stop), .request(request),
		.response(response), .memAddr(memAddr), .memWrData(memWrData), .memWe(memWe),
		.memRdData(memRdData));

	debugMemory memory (.CLK(CLK), .addr(memAddr), .wrData(memWrData), .we(memWe),
		.rdData(memRdData));

endmodule

/* testbench/debugClockGen.sv */
`timescale 1ns/1ns

module debugClockGen (
	output logic CLK,
	output logic reset
);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK; // 40 ns period.
	end

	// Reset covers the first ten rising edges and drops on the tenth.
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge CLK);
		reset <= 1'b0;
	end

endmodule

/* testbench/debugPort_assert.sv */
`timescale 1ns/1ns
`include "debug_defs.svh"

module debugPortAssert (
	input logic       CLK,
	input logic       reset,
	input logic [1:0] credits,
	input logic       requestValid,
	input logic       responseValid
);

	int pending;  // Requests sent to the executor that have no response yet.
	int inFlight; // Requests out before the last edge, counting the one on the bus then.

	always_ff @(posedge CLK) begin
		if (reset) begin
			pending  <= 0;
			inFlight <= 0;
		end else begin
			pending  <= pending + int'(requestValid) - int'(responseValid);
			inFlight <= pending + int'(requestValid);
		end
	end

	// The port chose this request one cycle earlier, when a credit had to be free.
	assert property (@(posedge CLK) disable iff (reset)
		requestValid |-> inFlight < `DEBUG_CREDITS)
		else $error("A request issued with no credit left.");

	assert property (@(posedge CLK) disable iff (reset) credits <= 2'(`DEBUG_CREDITS))
		else $error("The credit count rose above the queue depth.");

	// Every response answers a request that went out earlier.
	assert property (@(posedge CLK) disable iff (reset) responseValid |-> pending > 0)
		else $error("A response arrived without an outstanding request.");

endmodule

/* testbench/debugTb.sv */
`timescale 1ns/1ns
`include "debug_defs.svh"

module debugTb;

	// A table row either writes a host register, checks a read or polls status.
	typedef enum logic [1:0] {stepWrite, stepCheck, stepWait} stepKind;

	typedef struct packed {
		stepKind    kind;
		logic [2:0] addr;  // Host register.
		logic [7:0] value; // Byte to write, or the expected byte after masking.
		logic [7:0] mask;  // Bits that take part in a check or a poll.
	} tableStep;

	logic       CLK;
	logic       reset;
	logic [2:0] hostAddr;
	logic [7:0] hostDin;
	logic [7:0] hostDout;
	logic       hostRdn;
	logic       hostWrn;
	tableStep   steps [$];
	string      names [$]; // Test name of each row.
	int         cycles = 0;
	int         cycleLimit = 0;
	int         testChecks = 0;
	int         testErrors = 0;
	int         testCount = 0;
	int         failedTests = 0;
	int         totalChecks = 0;
	int         totalErrors = 0;

	debugClockGen clockGen (.CLK(CLK), .reset(reset));

	debugSubsystem DUT (.CLK(CLK), .reset(reset), .hostAddr(hostAddr), .hostDin(hostDin),
		.hostDout(hostDout), .hostRdn(hostRdn), .hostWrn(hostWrn));

	bind debugPort debugPortAssert portChecks (.CLK(CLK), .reset(reset),
		.credits(credits), .requestValid(request.valid), .responseValid(response.valid));

	// Op register byte. The opcode sits above the auto-increment bit.
	function automatic logic [7:0] opByte(input coreReqPkg::debugOp op, input logic autoInc);
		return {4'b0000, op, autoInc};
	endfunction

	task automatic addWrite(input string name, input logic [2:0] addr, input logic [7:0] data);
		steps.push_back('{kind: stepWrite, addr: addr, value: data, mask: 8'hFF});
		names.push_back(name);
	endtask

	task automatic addCheck(input string name, input logic [2:0] addr, input logic [7:0] data);
		steps.push_back('{kind: stepCheck, addr: addr, value: data, mask: 8'hFF});
		names.push_back(name);
	endtask

	task automatic addWait(input string name, input logic [7:0] mask, input logic [7:0] data);
		steps.push_back('{kind: stepWait, addr: `DEBUG_REG_STATUS, value: data, mask: mask});
		names.push_back(name);
	endtask

	task automatic addWord(input string name, input logic [15:0] word);
		addWrite(name, `DEBUG_REG_DL, word[7:0]);
		addWrite(name, `DEBUG_REG_DH, word[15:8]); // The high byte may trigger a request.
	endtask

	task automatic checkWord(input string name, input logic [15:0] word);
		addCheck(name, `DEBUG_REG_DL, word[7:0]);
		addCheck(name, `DEBUG_REG_DH, word[15:8]);
	endtask

	task automatic buildTable();
		logic [7:0]  alByte;
		logic [7:0]  ahByte;
		logic [15:0] start;
		logic [15:0] words [4];
		logic [15:0] reg3Val;
		logic [15:0] reg12Val;
		logic [15:0] pcVal;
		alByte   = 8'($urandom) | 8'h01; // Odd, so the forced zero in bit 0 shows.
		ahByte   = 8'($urandom);
		start    = 16'(($urandom % 120) * 2); // Even, and the last word stays below 256.
		reg3Val  = 16'($urandom);
		reg12Val = 16'($urandom);
		pcVal    = 16'($urandom);
		foreach (words[k])
			words[k] = 16'($urandom);
		addCheck("resetDefaults", `DEBUG_REG_STATUS, 8'h02); // Two credits and no flags.
		addCheck("resetDefaults", `DEBUG_REG_AL, 8'h00);
		addCheck("resetDefaults", `DEBUG_REG_AH, 8'h00);
		addCheck("resetDefaults", `DEBUG_REG_DL, 8'h00);
		addCheck("resetDefaults", `DEBUG_REG_DH, 8'h00);
		addWrite("addressReadBack", `DEBUG_REG_AL, alByte);
		addWrite("addressReadBack", `DEBUG_REG_AH, ahByte);
		addCheck("addressReadBack", `DEBUG_REG_AL, alByte & 8'hFE); // Word aligned.
		addCheck("addressReadBack", `DEBUG_REG_AH, ahByte);
		// The op write issues at once, so the start address is loaded after it.
		addWrite("memoryStream", `DEBUG_REG_MODE, 8'h01);
		addWrite("memoryStream", `DEBUG_REG_OP, opByte(coreReqPkg::opWriteMem, 1'b1));
		addWrite("memoryStream", `DEBUG_REG_AL, start[7:0]);
		addWrite("memoryStream", `DEBUG_REG_AH, start[15:8]);
		foreach (words[k])
			addWord("memoryStream", words[k]);
		addCheck("memoryStream", `DEBUG_REG_AL, start[7:0] + 8'd8);
		addWrite("memoryStream", `DEBUG_REG_AL, start[7:0]);
		foreach (words[k]) begin
			addWrite("memoryStream", `DEBUG_REG_OP, opByte(coreReqPkg::opReadMem, 1'b1));
			addWait("memoryStream", 8'h07, 8'h06); // Read data valid and both credits back.
			checkWord("memoryStream", words[k]);
		end
		addCheck("memoryStream", `DEBUG_REG_AL, start[7:0] + 8'd8);
		// A nop clears auto-increment so that DH writes stay quiet.
		addWrite("registerBank", `DEBUG_REG_OP, opByte(coreReqPkg::opNop, 1'b0));
		addWrite("registerBank", `DEBUG_REG_AL, 8'd6); // Register 3.
		addWrite("registerBank", `DEBUG_REG_AH, 8'd0);
		addWord("registerBank", reg3Val);
		addWrite("registerBank", `DEBUG_REG_OP, opByte(coreReqPkg::opWriteReg, 1'b0));
		addWrite("registerBank", `DEBUG_REG_AL, 8'd24); // Register 12.
		addWord("registerBank", reg12Val);
		addWrite("registerBank", `DEBUG_REG_OP, opByte(coreReqPkg::opWriteReg, 1'b0));
		addWord("registerBank", pcVal);
		addWrite("registerBank", `DEBUG_REG_OP, opByte(coreReqPkg::opWritePc, 1'b0));
		addWrite("registerBank", `DEBUG_REG_AL, 8'd6);
		addWrite("registerBank", `DEBUG_REG_OP, opByte(coreReqPkg::opReadReg, 1'b0));
		addWait("registerBank", 8'h07, 8'h06);
		checkWord("registerBank", reg3Val);
		addWrite("registerBank", `DEBUG_REG_AL, 8'd24);
		addWrite("registerBank", `DEBUG_REG_OP, opByte(coreReqPkg::opReadReg, 1'b0));
		addWait("registerBank", 8'h07, 8'h06);
		checkWord("registerBank", reg12Val);
		addWrite("registerBank", `DEBUG_REG_OP, opByte(coreReqPkg::opReadPc, 1'b0));
		addWait("registerBank", 8'h07, 8'h06);
		checkWord("registerBank", pcVal);
		// With the core running, two requests queue up and the third is dropped.
		addWrite("stopGating", `DEBUG_REG_MODE, 8'h00);
		addWait("stopGating", 8'h03, 8'h02);
		addWrite("stopGating", `DEBUG_REG_AL, 8'd6);
		repeat (3)
			addWrite("stopGating", `DEBUG_REG_OP, opByte(coreReqPkg::opReadReg, 1'b0));
		addCheck("stopGating", `DEBUG_REG_STATUS, 8'h08);
		addWrite("stopGating", `DEBUG_REG_MODE, 8'h03); // Stop and clear the flags.
		addWait("stopGating", 8'h0F, 8'h06);
		addCheck("stopGating", `DEBUG_REG_STATUS, 8'h06);
		checkWord("stopGating", reg3Val);
	endtask

	// Strobe low for two cycles, then five cycles for the event to cross over.
	task automatic writeByte(input logic [2:0] addr, input logic [7:0] data);
		@(posedge CLK);
		hostAddr <= addr;
		hostDin  <= data;
		hostWrn  <= 1'b0;
		repeat (2) @(posedge CLK);
		hostWrn <= 1'b1;
		repeat (5) @(posedge CLK);
	endtask

	task automatic readByte(input logic [2:0] addr, output logic [7:0] data);
		@(posedge CLK);
		hostAddr <= addr;
		hostRdn  <= 1'b0;
		@(negedge CLK); // The read path is combinational and settled here.
		data = hostDout;
		@(posedge CLK);
		hostRdn <= 1'b1;
	endtask

	task automatic applyStep(input int i);
		logic [7:0] got;
		case (steps[i].kind)
			stepWrite: writeByte(steps[i].addr, steps[i].value);
			stepCheck: begin
				readByte(steps[i].addr, got);
				testChecks++;
				if ((got & steps[i].mask) != steps[i].value) begin
					$display("FAILED %s register %0d expected 8'h%02h actual 8'h%02h",
						names[i], steps[i].addr, steps[i].value, got & steps[i].mask);
					testErrors++;
				end
			end
			default: begin
				readByte(steps[i].addr, got);
				while ((got & steps[i].mask) != steps[i].value) // The timeout bounds this.
					readByte(steps[i].addr, got);
			end
		endcase
	endtask

	task automatic closeTest(input string name);
		testCount++;
		if (testErrors == 0) begin
			$display("test %s passed, %0d checks", name, testChecks);
		end else begin
			$display("test %s failed, %0d of %0d checks wrong", name, testErrors, testChecks);
			failedTests++;
		end
		totalChecks += testChecks;
		totalErrors += testErrors;
		testChecks = 0;
		testErrors = 0;
	endtask

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("Timeout after %0d cycles, the DUT stopped answering the host", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		hostAddr = '0;
		hostDin  = '0;
		hostRdn  = 1'b1;
		hostWrn  = 1'b1;
		void'($urandom(32'hd00a));
		buildTable();
		cycleLimit = 40 * steps.size() + 200;
		@(negedge reset);
		for (int i = 0; i < steps.size(); i++) begin
			applyStep(i);
			if (i == steps.size() - 1 || names[i + 1] != names[i])
				closeTest(names[i]);
		end
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			testCount, failedTests, totalChecks, totalErrors);
		if (totalErrors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+design
design/debugPkg.sv
design/coreReqPkg.sv
design/debugSync.sv
design/debugPort.sv
design/debugExecutor.sv
design/debugMemory.sv
design/debugSubsystem.sv
testbench/debugClockGen.sv
testbench/debugPort_assert.sv
testbench/debugTb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module debugTb -f files.f -o simDebug \
	|| { echo "Build failed"; exit 1; }
./obj_dir/simDebug > sim.log 2>&1
status=$?
cat sim.log
[ $status -eq 0 ] && ! grep -q "Verification failed" sim.log \
	|| { echo "Simulation reported a failure"; exit 1; }
